/* design/exu_config.svh */
// execution unit width settings

`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// register file data width
`define EXU_XLEN 32

// register file address width, x0..x31
`define EXU_REG_ADDR_W 5

// iteration counter in the multiplier and the divider
// must hold XLEN-1
`define EXU_STEP_CNT_W 6

`endif

/* design/mdu_isa_pkg.sv */
// rv32m operation encodings
`default_nettype none

package mdu_isa_pkg;

    // same value as the funct3 field of an rv32m instruction
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHSU = 3'd2,
        MULHU  = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } mdu_op_t;

    // funct3 bit that selects the divider
    localparam int unsigned DIV_BIT = 2;

endpackage

`default_nettype wire

/* design/mdu_data_pkg.sv */
// arithmetic unit datapath words
`default_nettype none

`include "exu_config.svh"

package mdu_data_pkg;

    // upper and lower word of a double-width value
    typedef struct packed {
        logic [`EXU_XLEN-1:0] hi;
        logic [`EXU_XLEN-1:0] lo;
    } mdu_half_s;

    // iteration register
    // shifted as one word, read back as two halves
    // mul: hi/lo product, div: hi remainder and lo quotient
    typedef union packed {
        logic [2*`EXU_XLEN-1:0] word;
        mdu_half_s              half;
    } mdu_pair_u;

endpackage

`default_nettype wire

/* design/exu_mul.sv */
// iterative shift-add multiplier
`timescale 1ns/10ps
`default_nettype none

`include "exu_config.svh"

module exu_mul (
    input  wire                          clk,
    input  wire                          reset_i,
    input  wire                          start_i,
    input  wire                          flush_i,
    input  wire mdu_isa_pkg::mdu_op_t    op_i,
    input  wire [`EXU_XLEN-1:0]          op1_i,
    input  wire [`EXU_XLEN-1:0]          op2_i,
    output logic                         done_o,
    output logic [`EXU_XLEN-1:0]         result_o
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_CALC = 2'd1;
    localparam logic [1:0] ST_FIN  = 2'd2;
    localparam int LAST_STEP = `EXU_XLEN - 1;

    logic [1:0]                  state_q;
    logic [`EXU_STEP_CNT_W-1:0]  cnt_q;
    logic [`EXU_XLEN-1:0]        mcand_q;
    logic                        neg_q;
    logic                        hi_sel_q;
    mdu_data_pkg::mdu_pair_u     acc_q;
    mdu_data_pkg::mdu_pair_u     prod_fix;
    logic                        op1_signed;
    logic                        op2_signed;
    logic [`EXU_XLEN-1:0]        op1_abs;
    logic [`EXU_XLEN-1:0]        op2_abs;
    logic [`EXU_XLEN:0]          add_sum;

    always_comb begin
        // MULH signs both, MULHSU only rs1
        op1_signed = (op_i == mdu_isa_pkg::MULH) || (op_i == mdu_isa_pkg::MULHSU);
        op2_signed = (op_i == mdu_isa_pkg::MULH);
        op1_abs = (op1_signed && op1_i[`EXU_XLEN-1]) ? -op1_i : op1_i;
        op2_abs = (op2_signed && op2_i[`EXU_XLEN-1]) ? -op2_i : op2_i;
        // add multiplicand when the current multiplier bit is set
        add_sum = {1'b0, acc_q.half.hi} +
                  (acc_q.half.lo[0] ? {1'b0, mcand_q} : {(`EXU_XLEN+1){1'b0}});
        // sign correction of the full product
        prod_fix.word = neg_q ? -acc_q.word : acc_q.word;
    end

    // sequencing
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (flush_i) begin
                state_q <= ST_IDLE;
            end else begin
                case (state_q)
                    ST_IDLE: begin
                        if (start_i) begin
                            state_q <= ST_CALC;
                            cnt_q   <= '0;
                        end
                    end
                    ST_CALC: begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == LAST_STEP[`EXU_STEP_CNT_W-1:0]) begin
                            state_q <= ST_FIN;
                        end
                    end
                    default: begin
                        state_q <= ST_IDLE;
                        done_o  <= 1'b1;
                    end
                endcase
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && start_i) begin
            mcand_q       <= op1_abs;
            acc_q.half.hi <= '0;
            acc_q.half.lo <= op2_abs;
            neg_q    <= (op1_signed & op1_i[`EXU_XLEN-1]) ^ (op2_signed & op2_i[`EXU_XLEN-1]);
            hi_sel_q <= (op_i != mdu_isa_pkg::MUL);
        end else if (state_q == ST_CALC) begin
            // carry drops into the top, multiplier bits fall out the bottom
            acc_q.word <= {add_sum, acc_q.half.lo[`EXU_XLEN-1:1]};
        end else if (state_q == ST_FIN) begin
            result_o <= hi_sel_q ? prod_fix.half.hi : prod_fix.half.lo;
        end
    end

endmodule

`default_nettype wire

/* design/exu_div.sv */
// iterative restoring divider
`timescale 1ns/10ps
`default_nettype none

`include "exu_config.svh"

module exu_div (
    input  wire                          clk,
    input  wire                          reset_i,
    input  wire                          start_i,
    input  wire                          flush_i,
    input  wire mdu_isa_pkg::mdu_op_t    op_i,
    input  wire [`EXU_XLEN-1:0]          op1_i,
    input  wire [`EXU_XLEN-1:0]          op2_i,
    output logic                         done_o,
    output logic [`EXU_XLEN-1:0]         result_o
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_CALC = 2'd1;
    localparam logic [1:0] ST_FIN  = 2'd2;
    localparam int LAST_STEP = `EXU_XLEN - 1;

    logic [1:0]                  state_q;
    logic [`EXU_STEP_CNT_W-1:0]  cnt_q;
    logic [`EXU_XLEN-1:0]        dvsr_q;
    logic                        neg_quo_q;
    logic                        neg_rem_q;
    logic                        rem_sel_q;
    mdu_data_pkg::mdu_pair_u     acc_q;
    mdu_data_pkg::mdu_pair_u     shift_w;
    mdu_data_pkg::mdu_pair_u     nxt_w;
    logic                        is_signed;
    logic                        rem_sel;
    logic                        div_zero;
    logic                        div_ovf;
    logic [`EXU_XLEN-1:0]        op1_abs;
    logic [`EXU_XLEN-1:0]        op2_abs;
    logic [`EXU_XLEN:0]          trial;
    logic [`EXU_XLEN-1:0]        quo_fix;
    logic [`EXU_XLEN-1:0]        rem_fix;

    always_comb begin
        is_signed = (op_i == mdu_isa_pkg::DIV) || (op_i == mdu_isa_pkg::REM);
        rem_sel   = (op_i == mdu_isa_pkg::REM) || (op_i == mdu_isa_pkg::REMU);
        div_zero  = (op2_i == '0);
        // most negative dividend over -1
        div_ovf   = is_signed && (op1_i == {1'b1, {(`EXU_XLEN-1){1'b0}}}) && (&op2_i);
        op1_abs = (is_signed && op1_i[`EXU_XLEN-1]) ? -op1_i : op1_i;
        op2_abs = (is_signed && op2_i[`EXU_XLEN-1]) ? -op2_i : op2_i;
        // shift remainder:quotient left, bring the next dividend bit in
        shift_w.word = acc_q.word << 1;
        trial = {acc_q.half.hi[`EXU_XLEN-1], shift_w.half.hi} - {1'b0, dvsr_q};
        nxt_w = shift_w;
        // no borrow, keep the difference and set the quotient bit
        if (!trial[`EXU_XLEN]) begin
            nxt_w.half.hi    = trial[`EXU_XLEN-1:0];
            nxt_w.half.lo[0] = 1'b1;
        end
        quo_fix = neg_quo_q ? -acc_q.half.lo : acc_q.half.lo;
        rem_fix = neg_rem_q ? -acc_q.half.hi : acc_q.half.hi;
    end

    // sequencing
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (flush_i) begin
                state_q <= ST_IDLE;
            end else begin
                case (state_q)
                    ST_IDLE: begin
                        if (start_i) begin
                            cnt_q <= '0;
                            // special cases answer straight away
                            if (div_zero || div_ovf) begin
                                done_o <= 1'b1;
                            end else begin
                                state_q <= ST_CALC;
                            end
                        end
                    end
                    ST_CALC: begin
                        cnt_q <= cnt_q + 1'b1;
                        if (cnt_q == LAST_STEP[`EXU_STEP_CNT_W-1:0]) begin
                            state_q <= ST_FIN;
                        end
                    end
                    default: begin
                        state_q <= ST_IDLE;
                        done_o  <= 1'b1;
                    end
                endcase
            end
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && start_i) begin
            dvsr_q        <= op2_abs;
            acc_q.half.hi <= '0;
            acc_q.half.lo <= op1_abs;
            neg_quo_q <= is_signed && (op1_i[`EXU_XLEN-1] ^ op2_i[`EXU_XLEN-1]);
            // remainder follows the dividend sign
            neg_rem_q <= is_signed && op1_i[`EXU_XLEN-1];
            rem_sel_q <= rem_sel;
            if (div_zero) begin
                result_o <= rem_sel ? op1_i : '1;
            end else if (div_ovf) begin
                result_o <= rem_sel ? '0 : op1_i;
            end
        end else if (state_q == ST_CALC) begin
            acc_q <= nxt_w;
        end else if (state_q == ST_FIN) begin
            result_o <= rem_sel_q ? rem_fix : quo_fix;
        end
    end

endmodule

`default_nettype wire

/* design/exu_muldiv_ctrl.sv */
// multiply/divide request and writeback control
`timescale 1ns/10ps
`default_nettype none

`include "exu_config.svh"

module exu_muldiv_ctrl (
    input  wire                          clk,
    input  wire                          reset_i,
    // request side
    input  wire                          req_i,
    input  wire mdu_isa_pkg::mdu_op_t    op_i,
    input  wire [`EXU_XLEN-1:0]          rs1_i,
    input  wire [`EXU_XLEN-1:0]          rs2_i,
    input  wire [`EXU_REG_ADDR_W-1:0]    rd_i,
    input  wire                          int_assert_i,
    // pipeline stall and register write
    output logic                         hold_o,
    output logic                         reg_we_o,
    output logic [`EXU_REG_ADDR_W-1:0]   reg_waddr_o,
    output logic [`EXU_XLEN-1:0]         reg_wdata_o,
    // shared to both units
    output mdu_isa_pkg::mdu_op_t         op_o,
    output logic [`EXU_XLEN-1:0]         op1_o,
    output logic [`EXU_XLEN-1:0]         op2_o,
    output logic                         flush_o,
    // multiplier
    output logic                         mul_start_o,
    input  wire                          mul_done_i,
    input  wire [`EXU_XLEN-1:0]          mul_result_i,
    // divider
    output logic                         div_start_o,
    input  wire                          div_done_i,
    input  wire [`EXU_XLEN-1:0]          div_result_i
);

    logic busy_q;
    logic accept;
    logic unit_done;

    // new work only when idle and no interrupt pending
    assign accept    = req_i && !busy_q && !int_assert_i;
    assign unit_done = mul_done_i || div_done_i;
    assign hold_o    = busy_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q      <= 1'b0;
            mul_start_o <= 1'b0;
            div_start_o <= 1'b0;
            flush_o     <= 1'b0;
            reg_we_o    <= 1'b0;
        end else begin
            // route the start by the divide bit of funct3
            mul_start_o <= accept && !op_i[mdu_isa_pkg::DIV_BIT];
            div_start_o <= accept && op_i[mdu_isa_pkg::DIV_BIT];
            // interrupt kills whatever is running
            flush_o  <= busy_q && int_assert_i;
            // done from a cancelled op arrives with busy low, dropped here
            reg_we_o <= busy_q && !int_assert_i && unit_done;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (busy_q && (int_assert_i || reg_we_o)) begin
                // release one cycle after the write
                busy_q <= 1'b0;
            end
        end
    end

    // request payload and result
    always_ff @(posedge clk) begin
        if (accept) begin
            op_o        <= op_i;
            op1_o       <= rs1_i;
            op2_o       <= rs2_i;
            reg_waddr_o <= rd_i;
        end
        if (unit_done) begin
            reg_wdata_o <= mul_done_i ? mul_result_i : div_result_i;
        end
    end

endmodule

`default_nettype wire

/* design/exu_muldiv_top.sv */
// rv32m multiply/divide execution path
`timescale 1ns/10ps
`default_nettype none

`include "exu_config.svh"

module exu_muldiv_top (
    input  wire                          clk,
    input  wire                          reset_i,
    input  wire                          req_i,
    input  wire mdu_isa_pkg::mdu_op_t    op_i,
    input  wire [`EXU_XLEN-1:0]          rs1_i,
    input  wire [`EXU_XLEN-1:0]          rs2_i,
    input  wire [`EXU_REG_ADDR_W-1:0]    rd_i,
    input  wire                          int_assert_i,
    output wire                          hold_o,
    output wire                          reg_we_o,
    output wire [`EXU_REG_ADDR_W-1:0]    reg_waddr_o,
    output wire [`EXU_XLEN-1:0]          reg_wdata_o
);

    // latched request towards the units
    mdu_isa_pkg::mdu_op_t  unit_op;
    wire [`EXU_XLEN-1:0]   unit_op1;
    wire [`EXU_XLEN-1:0]   unit_op2;
    wire                   unit_flush;
    // multiplier handshake
    wire                   mul_start;
    wire                   mul_done;
    wire [`EXU_XLEN-1:0]   mul_result;
    // divider handshake
    wire                   div_start;
    wire                   div_done;
    wire [`EXU_XLEN-1:0]   div_result;

    exu_muldiv_ctrl u_muldiv_ctrl (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_i        (req_i),
        .op_i         (op_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .rd_i         (rd_i),
        .int_assert_i (int_assert_i),
        .hold_o       (hold_o),
        .reg_we_o     (reg_we_o),
        .reg_waddr_o  (reg_waddr_o),
        .reg_wdata_o  (reg_wdata_o),
        .op_o         (unit_op),
        .op1_o        (unit_op1),
        .op2_o        (unit_op2),
        .flush_o      (unit_flush),
        .mul_start_o  (mul_start),
        .mul_done_i   (mul_done),
        .mul_result_i (mul_result),
        .div_start_o  (div_start),
        .div_done_i   (div_done),
        .div_result_i (div_result)
    );

    exu_mul u_mul (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (mul_start),
        .flush_i  (unit_flush),
        .op_i     (unit_op),
        .op1_i    (unit_op1),
        .op2_i    (unit_op2),
        .done_o   (mul_done),
        .result_o (mul_result)
    );

    exu_div u_div (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (div_start),
        .flush_i  (unit_flush),
        .op_i     (unit_op),
        .op1_i    (unit_op1),
        .op2_i    (unit_op2),
        .done_o   (div_done),
        .result_o (div_result)
    );

endmodule

`default_nettype wire

/* tests/tb_exu_muldiv.sv */
// multiply/divide execution path testbench
`timescale 1ns/10ps
`default_nettype none

`include "exu_config.svh"

module tb_exu_muldiv;

    // longest acceptance to write time in cycles
    localparam int MAX_LATENCY = 40;
    // budget of every wait loop
    localparam int WAIT_LIMIT = 100;
    localparam logic [`EXU_XLEN-1:0] MOST_NEG = {1'b1, {(`EXU_XLEN-1){1'b0}}};

    logic                         clk;
    logic                         reset_i;
    logic                         req_i;
    mdu_isa_pkg::mdu_op_t         op_i;
    logic [`EXU_XLEN-1:0]         rs1_i;
    logic [`EXU_XLEN-1:0]         rs2_i;
    logic [`EXU_REG_ADDR_W-1:0]   rd_i;
    logic                         int_assert_i;
    wire                          hold_o;
    wire                          reg_we_o;
    wire [`EXU_REG_ADDR_W-1:0]    reg_waddr_o;
    wire [`EXU_XLEN-1:0]          reg_wdata_o;

    integer seed;

    exu_muldiv_top i_exu_muldiv_top (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_i        (req_i),
        .op_i         (op_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .rd_i         (rd_i),
        .int_assert_i (int_assert_i),
        .hold_o       (hold_o),
        .reg_we_o     (reg_we_o),
        .reg_waddr_o  (reg_waddr_o),
        .reg_wdata_o  (reg_wdata_o)
    );

    // 10 ns clock
    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [`EXU_XLEN-1:0] exp,
                              input logic [`EXU_XLEN-1:0] act);
        if (act !== exp) begin
            report_failure($sformatf("MISMATCH %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_rd(input string name, input logic [`EXU_REG_ADDR_W-1:0] exp,
                            input logic [`EXU_REG_ADDR_W-1:0] act);
        if (act !== exp) begin
            report_failure($sformatf("MISMATCH %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("MISMATCH %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // reference model in double-width arithmetic
    function automatic logic [`EXU_XLEN-1:0] model_result(input mdu_isa_pkg::mdu_op_t op,
                                                          input logic [`EXU_XLEN-1:0] a,
                                                          input logic [`EXU_XLEN-1:0] b);
        logic signed [2*`EXU_XLEN-1:0] sa;
        logic signed [2*`EXU_XLEN-1:0] sb;
        logic [2*`EXU_XLEN-1:0]        ua;
        logic [2*`EXU_XLEN-1:0]        ub;
        logic [2*`EXU_XLEN-1:0]        wide;
        logic                          ovf;
        sa  = {{`EXU_XLEN{a[`EXU_XLEN-1]}}, a};
        sb  = {{`EXU_XLEN{b[`EXU_XLEN-1]}}, b};
        ua  = {{`EXU_XLEN{1'b0}}, a};
        ub  = {{`EXU_XLEN{1'b0}}, b};
        ovf = (a == MOST_NEG) && (b == '1);
        case (op)
            mdu_isa_pkg::MULH:   wide = sa * sb;
            // signed rs1 times unsigned rs2
            mdu_isa_pkg::MULHSU: wide = sa * $signed(ub);
            mdu_isa_pkg::DIV: begin
                if (b == '0) begin
                    wide = '1;
                end else if (ovf) begin
                    wide = ua;
                end else begin
                    wide = sa / sb;
                end
            end
            mdu_isa_pkg::DIVU: begin
                wide = (b == '0) ? '1 : ua / ub;
            end
            mdu_isa_pkg::REM: begin
                if (b == '0) begin
                    wide = ua;
                end else if (ovf) begin
                    wide = '0;
                end else begin
                    // sign follows the dividend
                    wide = sa % sb;
                end
            end
            mdu_isa_pkg::REMU: begin
                wide = (b == '0) ? ua : ua % ub;
            end
            default:             wide = ua * ub;
        endcase
        // only MULH* return the upper half
        if ((op == mdu_isa_pkg::MUL) || op[2]) begin
            model_result = wide[`EXU_XLEN-1:0];
        end else begin
            model_result = wide[2*`EXU_XLEN-1:`EXU_XLEN];
        end
    endfunction

    // corner values now and then
    function automatic logic [`EXU_XLEN-1:0] pick_operand();
        logic [31:0] r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    pick_operand = '0;
            3'd1:    pick_operand = '1;
            3'd2:    pick_operand = MOST_NEG;
            3'd3:    pick_operand = {{(`EXU_XLEN-8){1'b0}}, r[15:8]};
            default: pick_operand = $random(seed);
        endcase
    endfunction

    // returns right after the acceptance edge
    task automatic issue_request(input mdu_isa_pkg::mdu_op_t op, input logic [`EXU_XLEN-1:0] a,
                                 input logic [`EXU_XLEN-1:0] b,
                                 input logic [`EXU_REG_ADDR_W-1:0] rd);
        @(posedge clk);
        req_i <= 1'b1;
        op_i  <= op;
        rs1_i <= a;
        rs2_i <= b;
        rd_i  <= rd;
        @(posedge clk);
        req_i <= 1'b0;
    endtask

    task automatic wait_write(input string name, input logic [`EXU_REG_ADDR_W-1:0] exp_rd,
                              input logic [`EXU_XLEN-1:0] exp_data);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!reg_we_o && cycles < WAIT_LIMIT) begin
            // stall must cover the whole operation
            check_flag({name, " hold_o while busy"}, 1'b1, hold_o);
            @(negedge clk);
            cycles++;
        end
        if (!reg_we_o) begin
            report_failure($sformatf("timeout: no register write for %s within %0d cycles",
                                     name, WAIT_LIMIT));
        end else begin
            check_flag({name, " hold_o in write cycle"}, 1'b1, hold_o);
            check_flag({name, " latency"}, 1'b1, (cycles + 1) <= MAX_LATENCY);
            check_rd({name, " reg_waddr_o"}, exp_rd, reg_waddr_o);
            check_word({name, " reg_wdata_o"}, exp_data, reg_wdata_o);
            // one pulse only and the stall released
            @(negedge clk);
            check_flag({name, " reg_we_o after write"}, 1'b0, reg_we_o);
            check_flag({name, " hold_o after write"}, 1'b0, hold_o);
        end
    endtask

    task automatic wait_hold_fall(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (hold_o && cycles < WAIT_LIMIT) begin
            check_flag({name, " reg_we_o while cancelling"}, 1'b0, reg_we_o);
            @(negedge clk);
            cycles++;
        end
        if (hold_o) begin
            report_failure($sformatf("timeout: hold_o did not fall for %s within %0d cycles",
                                     name, WAIT_LIMIT));
        end
    endtask

    task automatic expect_no_write(input string name, input int n);
        repeat (n) begin
            @(negedge clk);
            check_flag({name, " reg_we_o idle"}, 1'b0, reg_we_o);
            check_flag({name, " hold_o idle"}, 1'b0, hold_o);
        end
    endtask

    task automatic run_op(input string name, input mdu_isa_pkg::mdu_op_t op,
                          input logic [`EXU_XLEN-1:0] a, input logic [`EXU_XLEN-1:0] b,
                          input logic [`EXU_REG_ADDR_W-1:0] rd);
        logic [`EXU_XLEN-1:0] exp;
        exp = model_result(op, a, b);
        issue_request(op, a, b, rd);
        wait_write(name, rd, exp);
    endtask

    initial begin
        int                          i;
        logic [31:0]                 r;
        mdu_isa_pkg::mdu_op_t        op;
        logic [`EXU_XLEN-1:0]        a;
        logic [`EXU_XLEN-1:0]        b;
        logic [`EXU_REG_ADDR_W-1:0]  rd;
        seed = 32'hf7eb;
        reset_i      <= 1'b1;
        req_i        <= 1'b0;
        op_i         <= mdu_isa_pkg::MUL;
        rs1_i        <= '0;
        rs2_i        <= '0;
        rd_i         <= '0;
        int_assert_i <= 1'b0;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;

        // quiet after reset
        expect_no_write("reset", 8);

        // multiply family
        for (i = 0; i < 200; i++) begin
            r  = $random(seed);
            op = mdu_isa_pkg::mdu_op_t'({1'b0, r[1:0]});
            a  = pick_operand();
            b  = pick_operand();
            run_op($sformatf("mul %s #%0d", op.name(), i), op, a, b, r[6:2]);
        end

        // divide family with zero divisors from pick_operand
        for (i = 0; i < 200; i++) begin
            r  = $random(seed);
            op = mdu_isa_pkg::mdu_op_t'({1'b1, r[1:0]});
            a  = pick_operand();
            b  = pick_operand();
            if (r[9:7] == 3'd0) begin
                // signed overflow pair
                a = MOST_NEG;
                b = '1;
            end
            run_op($sformatf("div %s #%0d", op.name(), i), op, a, b, r[6:2]);
        end

        // second request while a long multiply stalls the pipe
        a  = $random(seed);
        b  = $random(seed);
        rd = 5'd7;
        issue_request(mdu_isa_pkg::MULHU, a, b, rd);
        repeat (3) @(posedge clk);
        req_i <= 1'b1;
        op_i  <= mdu_isa_pkg::DIV;
        rs1_i <= ~a;
        rs2_i <= ~b;
        rd_i  <= ~rd;
        @(posedge clk);
        req_i <= 1'b0;
        wait_write("back-pressure", rd, model_result(mdu_isa_pkg::MULHU, a, b));
        expect_no_write("back-pressure extra", 50);

        // interrupt cancels divider then multiplier
        for (i = 0; i < 2; i++) begin
            op   = (i == 0) ? mdu_isa_pkg::DIVU : mdu_isa_pkg::MULHU;
            a    = $random(seed);
            b    = $random(seed);
            // nonzero divisor runs the full length
            b[0] = 1'b1;
            issue_request(op, a, b, 5'd9);
            repeat (5) @(posedge clk);
            int_assert_i <= 1'b1;
            @(posedge clk);
            int_assert_i <= 1'b0;
            wait_hold_fall($sformatf("interrupt %s", op.name()));
            // same unit again while the cancelled op would still be running
            run_op($sformatf("after cancel %s", op.name()), op, ~a, b, 5'd10);
            expect_no_write($sformatf("interrupt %s", op.name()), WAIT_LIMIT);
        end

        // request while the interrupt is high is dropped
        @(posedge clk);
        int_assert_i <= 1'b1;
        req_i        <= 1'b1;
        op_i         <= mdu_isa_pkg::MULHU;
        rs1_i        <= a;
        rs2_i        <= b;
        rd_i         <= 5'd11;
        @(posedge clk);
        req_i        <= 1'b0;
        int_assert_i <= 1'b0;
        expect_no_write("request under interrupt", 20);

        // normal operation afterwards
        run_op("after interrupt mul", mdu_isa_pkg::MULH, a, b, 5'd13);
        run_op("after interrupt div", mdu_isa_pkg::REM, a, b, 5'd14);

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+design
design/mdu_isa_pkg.sv
design/mdu_data_pkg.sv
design/exu_mul.sv
design/exu_div.sv
design/exu_muldiv_ctrl.sv
design/exu_muldiv_top.sv
tests/tb_exu_muldiv.sv

/* Makefile */
TOP := tb_exu_muldiv

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f list.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
